//--- hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN       32   // data and address width
`define DMEM_WORDS 256  // data ram depth, power of two
`define NREGS      32

`endif

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // ########################################################################
    // machine csr addresses
    // ########################################################################
    typedef enum logic [11:0] {
        MTVEC          = 12'h305,
        MSCRATCH       = 12'h340,
        MEPC           = 12'h341,
        MCAUSE         = 12'h342
    } csr_addr_e;

    // low bits of funct3 for csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // ########################################################################
    // memory access size, as funct3[1:0]
    // ########################################################################
    typedef enum logic [1:0] {
        SZ_B = 2'b00,
        SZ_H = 2'b01,
        SZ_W = 2'b10
    } mem_size_e;

    localparam int unsigned CAUSE_ECALL_M = 11;  // environment call from m-mode

endpackage

//--- hw/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        CL_ALU    = 3'd0,
        CL_LOAD   = 3'd1,
        CL_STORE  = 3'd2,
        CL_CSR    = 3'd3,
        CL_ECALL  = 3'd4,
        CL_FENCEI = 3'd5
    } instr_class_e;

    // load / store view of the op control word
    typedef struct packed {
        logic [8:0] pad;
        logic       unsigned_ld;  // lbu / lhu
        mem_size_e  size;
    } mem_ctrl_t;

    // class picks the view: mem for loads and stores, csr for csr ops
    typedef union packed {
        mem_ctrl_t mem;
        csr_addr_e csr;
    } op_ctrl_u;

endpackage

//--- hw/lsu_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module lsu_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        issue_valid_i,
    input  pipe_pkg::instr_class_e      issue_class_i,
    input  logic [`XLEN-1:0]            issue_pc_i,
    input  logic [$clog2(`NREGS)-1:0]   issue_rd_i,
    input  rv_isa_pkg::csr_op_e         issue_csr_op_i,
    input  pipe_pkg::op_ctrl_u          issue_ctrl_i,
    input  logic [`XLEN-1:0]            issue_result_i,
    input  logic [`XLEN-1:0]            issue_store_data_i,
    input  logic                        squash_i,
    output logic                        valid_o,
    output pipe_pkg::instr_class_e      class_o,
    output logic [`XLEN-1:0]            pc_o,
    output logic [$clog2(`NREGS)-1:0]   rd_o,
    output rv_isa_pkg::csr_op_e         csr_op_o,
    output pipe_pkg::op_ctrl_u          ctrl_o,
    output logic [`XLEN-1:0]            result_o,
    output logic [`XLEN-1:0]            rdata_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int unsigned AW    = $clog2(`DMEM_WORDS);
    localparam int unsigned LANES = `XLEN / 8;

    logic                      valid_q;
    instr_class_e              class_q;
    logic [`XLEN-1:0]          pc_q;
    logic [$clog2(`NREGS)-1:0] rd_q;
    csr_op_e                   csr_op_q;
    op_ctrl_u                  ctrl_q;
    logic [`XLEN-1:0]          result_q;
    logic [`XLEN-1:0]          store_data_q;

    logic [`XLEN-1:0]          dmem [`DMEM_WORDS];
    logic [`XLEN-1:0]          rdata_q;
    logic [AW-1:0]             word_addr;
    logic [LANES-1:0]          lane_en;
    logic [`XLEN-1:0]          wdata;
    logic                      st_en;

    // ########################################################################
    // stage register
    // ########################################################################
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i & ~squash_i;  // drop issue during a flush
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid_i) begin
            class_q      <= issue_class_i;
            pc_q         <= issue_pc_i;
            rd_q         <= issue_rd_i;
            csr_op_q     <= issue_csr_op_i;
            ctrl_q       <= issue_ctrl_i;
            result_q     <= issue_result_i;
            store_data_q <= issue_store_data_i;
        end
    end

    // ########################################################################
    // data ram with byte lanes
    // ########################################################################
    assign word_addr = result_q[AW+1:2];
    assign st_en     = valid_q & ~squash_i & (class_q == CL_STORE);

    always_comb begin
        case (ctrl_q.mem.size)
            SZ_B: begin
                lane_en = LANES'(1) << result_q[1:0];
                wdata   = {LANES{store_data_q[7:0]}};
            end
            SZ_H: begin
                lane_en = LANES'(3) << {result_q[1], 1'b0};
                wdata   = {(LANES/2){store_data_q[15:0]}};
            end
            default: begin
                lane_en = '1;
                wdata   = store_data_q;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (st_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en[i]) dmem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rdata_q <= dmem[word_addr];  // lines up with the writeback register
    end

    assign valid_o  = valid_q & ~squash_i;
    assign class_o  = class_q;
    assign pc_o     = pc_q;
    assign rd_o     = rd_q;
    assign csr_op_o = csr_op_q;
    assign ctrl_o   = ctrl_q;
    assign result_o = result_q;
    assign rdata_o  = rdata_q;

    a_store_word_aligned: assert property (@(posedge clock) disable iff (reset)
        st_en |-> !(ctrl_q.mem.size == SZ_W && result_q[1:0] != 2'b00));

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module wb_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        valid_i,
    input  pipe_pkg::instr_class_e      class_i,
    input  logic [`XLEN-1:0]            pc_i,
    input  logic [$clog2(`NREGS)-1:0]   rd_i,
    input  rv_isa_pkg::csr_op_e         csr_op_i,
    input  pipe_pkg::op_ctrl_u          ctrl_i,
    input  logic [`XLEN-1:0]            result_i,
    input  logic [`XLEN-1:0]            rdata_i,     // already registered in the ram
    input  logic [`XLEN-1:0]            csr_rdata_i,
    input  logic [`XLEN-1:0]            mtvec_i,
    output logic                        rf_we_o,
    output logic [$clog2(`NREGS)-1:0]   rf_waddr_o,
    output logic [`XLEN-1:0]            rf_wdata_o,
    output logic                        csr_en_o,
    output rv_isa_pkg::csr_op_e         csr_op_o,
    output rv_isa_pkg::csr_addr_e       csr_addr_o,
    output logic [`XLEN-1:0]            csr_src_o,
    output logic                        trap_en_o,
    output logic [`XLEN-1:0]            trap_pc_o,
    output logic                        flush_valid_o,
    output logic [`XLEN-1:0]            flush_pc_o,
    output logic                        retire_valid_o,
    output logic [`XLEN-1:0]            retire_pc_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic                      valid_q;
    instr_class_e              class_q;
    logic [`XLEN-1:0]          pc_q;
    logic [$clog2(`NREGS)-1:0] rd_q;
    csr_op_e                   csr_op_q;
    op_ctrl_u                  ctrl_q;
    logic [`XLEN-1:0]          result_q;

    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;
    logic                      ld_sign;
    logic [`XLEN-1:0]          ld_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (valid_i) begin
            class_q  <= class_i;
            pc_q     <= pc_i;
            rd_q     <= rd_i;
            csr_op_q <= csr_op_i;
            ctrl_q   <= ctrl_i;
            result_q <= result_i;
        end
    end

    // ########################################################################
    // load extraction and register write data
    // ########################################################################
    assign ld_byte = rdata_i[8*result_q[1:0] +: 8];
    assign ld_half = rdata_i[16*result_q[1] +: 16];

    always_comb begin
        ld_sign = 1'b0;
        case (ctrl_q.mem.size)
            SZ_B: begin
                ld_sign = ~ctrl_q.mem.unsigned_ld & ld_byte[7];
                ld_data = {{(`XLEN-8){ld_sign}}, ld_byte};
            end
            SZ_H: begin
                ld_sign = ~ctrl_q.mem.unsigned_ld & ld_half[15];
                ld_data = {{(`XLEN-16){ld_sign}}, ld_half};
            end
            default: ld_data = rdata_i;
        endcase
    end

    always_comb begin
        case (class_q)
            CL_LOAD: rf_wdata_o = ld_data;
            CL_CSR:  rf_wdata_o = csr_rdata_i;  // old csr value
            default: rf_wdata_o = result_q;
        endcase
    end

    assign rf_we_o    = valid_q & (class_q == CL_ALU || class_q == CL_LOAD
                                   || class_q == CL_CSR);
    assign rf_waddr_o = rd_q;

    // csr access and trap
    assign csr_en_o   = valid_q & (class_q == CL_CSR);
    assign csr_op_o   = csr_op_q;
    assign csr_addr_o = ctrl_q.csr;
    assign csr_src_o  = result_q;
    assign trap_en_o  = valid_q & (class_q == CL_ECALL);
    assign trap_pc_o  = pc_q;

    assign flush_valid_o  = valid_q & (class_q == CL_ECALL || class_q == CL_FENCEI);
    assign flush_pc_o     = (class_q == CL_ECALL) ? mtvec_i : pc_q + `XLEN'(4);
    assign retire_valid_o = valid_q;
    assign retire_pc_o    = pc_q;

    a_no_wr_on_trap: assert property (@(posedge clock) disable iff (reset)
        !(rf_we_o && trap_en_o));

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        we_i,
    input  logic [$clog2(`NREGS)-1:0]   waddr_i,
    input  logic [`XLEN-1:0]            wdata_i,
    input  logic [$clog2(`NREGS)-1:0]   raddr_i,
    output logic [`XLEN-1:0]            rdata_o
);
    logic [`XLEN-1:0] regs [`NREGS];
    logic             wr_live;

    assign wr_live = we_i & (waddr_i != '0);  // x0 stays zero

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so writeback is visible one cycle early
    assign rdata_o = (wr_live && waddr_i == raddr_i) ? wdata_i : regs[raddr_i];

endmodule

//--- hw/csr_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module csr_file (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    csr_en_i,
    input  rv_isa_pkg::csr_op_e     csr_op_i,
    input  rv_isa_pkg::csr_addr_e   csr_addr_i,
    input  logic [`XLEN-1:0]        csr_src_i,
    input  logic                    trap_en_i,
    input  logic [`XLEN-1:0]        trap_pc_i,
    output logic [`XLEN-1:0]        csr_rdata_o,
    output logic [`XLEN-1:0]        mtvec_o
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] csr_new;

    always_comb begin
        case (csr_addr_i)
            MSCRATCH: csr_rdata_o = mscratch_q;
            MTVEC:    csr_rdata_o = mtvec_q;
            MEPC:     csr_rdata_o = mepc_q;
            MCAUSE:   csr_rdata_o = mcause_q;
            default:  csr_rdata_o = '0;
        endcase
    end

    // read-modify-write on the old value
    always_comb begin
        case (csr_op_i)
            CSR_RW:  csr_new = csr_src_i;
            CSR_RS:  csr_new = csr_rdata_o | csr_src_i;
            CSR_RC:  csr_new = csr_rdata_o & ~csr_src_i;
            default: csr_new = csr_rdata_o;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (trap_en_i) begin
            mepc_q   <= trap_pc_i;
            mcause_q <= `XLEN'(CAUSE_ECALL_M);
        end else if (csr_en_i) begin
            case (csr_addr_i)
                MSCRATCH: mscratch_q <= csr_new;
                MTVEC:    mtvec_q    <= csr_new;
                MEPC:     mepc_q     <= csr_new;
                MCAUSE:   mcause_q   <= csr_new;
                default:  ;
            endcase
        end
    end

    assign mtvec_o = {mtvec_q[`XLEN-1:2], 2'b00};  // direct mode only

    a_csr_addr_known: assert property (@(posedge clock) disable iff (reset)
        csr_en_i |-> csr_addr_i inside {MSCRATCH, MTVEC, MEPC, MCAUSE});

endmodule

//--- hw/backend_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module backend_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        issue_valid_i,
    input  pipe_pkg::instr_class_e      issue_class_i,
    input  logic [`XLEN-1:0]            issue_pc_i,
    input  logic [$clog2(`NREGS)-1:0]   issue_rd_i,
    input  rv_isa_pkg::csr_op_e         issue_csr_op_i,
    input  pipe_pkg::op_ctrl_u          issue_ctrl_i,
    input  logic [`XLEN-1:0]            issue_result_i,
    input  logic [`XLEN-1:0]            issue_store_data_i,
    input  logic [$clog2(`NREGS)-1:0]   rs_addr_i,
    output logic [`XLEN-1:0]            rs_data_o,
    output logic                        retire_valid_o,
    output logic [`XLEN-1:0]            retire_pc_o,
    output logic                        flush_valid_o,
    output logic [`XLEN-1:0]            flush_pc_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    // memory stage to writeback
    logic                      lsu_valid;
    instr_class_e              lsu_class;
    logic [`XLEN-1:0]          lsu_pc;
    logic [$clog2(`NREGS)-1:0] lsu_rd;
    csr_op_e                   lsu_csr_op;
    op_ctrl_u                  lsu_ctrl;
    logic [`XLEN-1:0]          lsu_result;
    logic [`XLEN-1:0]          lsu_rdata;

    // writeback to state
    logic                      rf_we;
    logic [$clog2(`NREGS)-1:0] rf_waddr;
    logic [`XLEN-1:0]          rf_wdata;
    logic                      csr_en;
    csr_op_e                   csr_op;
    csr_addr_e                 csr_addr;
    logic [`XLEN-1:0]          csr_src;
    logic                      trap_en;
    logic [`XLEN-1:0]          trap_pc;
    logic [`XLEN-1:0]          csr_rdata;
    logic [`XLEN-1:0]          mtvec;

    lsu_stage u_lsu (
        .clock              (clock),
        .reset              (reset),
        .issue_valid_i      (issue_valid_i),
        .issue_class_i      (issue_class_i),
        .issue_pc_i         (issue_pc_i),
        .issue_rd_i         (issue_rd_i),
        .issue_csr_op_i     (issue_csr_op_i),
        .issue_ctrl_i       (issue_ctrl_i),
        .issue_result_i     (issue_result_i),
        .issue_store_data_i (issue_store_data_i),
        .squash_i           (flush_valid_o),
        .valid_o            (lsu_valid),
        .class_o            (lsu_class),
        .pc_o               (lsu_pc),
        .rd_o               (lsu_rd),
        .csr_op_o           (lsu_csr_op),
        .ctrl_o             (lsu_ctrl),
        .result_o           (lsu_result),
        .rdata_o            (lsu_rdata)
    );

    wb_stage u_wb (
        .clock          (clock),
        .reset          (reset),
        .valid_i        (lsu_valid),
        .class_i        (lsu_class),
        .pc_i           (lsu_pc),
        .rd_i           (lsu_rd),
        .csr_op_i       (lsu_csr_op),
        .ctrl_i         (lsu_ctrl),
        .result_i       (lsu_result),
        .rdata_i        (lsu_rdata),
        .csr_rdata_i    (csr_rdata),
        .mtvec_i        (mtvec),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .csr_en_o       (csr_en),
        .csr_op_o       (csr_op),
        .csr_addr_o     (csr_addr),
        .csr_src_o      (csr_src),
        .trap_en_o      (trap_en),
        .trap_pc_o      (trap_pc),
        .flush_valid_o  (flush_valid_o),
        .flush_pc_o     (flush_pc_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o)
    );

    reg_file u_rf (
        .clock   (clock),
        .reset   (reset),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

    csr_file u_csr (
        .clock       (clock),
        .reset       (reset),
        .csr_en_i    (csr_en),
        .csr_op_i    (csr_op),
        .csr_addr_i  (csr_addr),
        .csr_src_i   (csr_src),
        .trap_en_i   (trap_en),
        .trap_pc_i   (trap_pc),
        .csr_rdata_o (csr_rdata),
        .mtvec_o     (mtvec)
    );

endmodule

//--- tb/backend_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module backend_tb;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int MAX_REC = 40;
    localparam int FIELDS  = 9;   // words per pattern record
    // idle + init + alu + mem + csr sweeps, in cycles
    localparam int SWEEP_CYCLES = 16 + 16 + 16 * 3 + 24 * 4 + 12 * 6;

    logic                 clock;
    logic                 reset;
    logic                 issue_valid_i;
    instr_class_e         issue_class_i;
    logic [`XLEN-1:0]     issue_pc_i;
    logic [4:0]           issue_rd_i;
    csr_op_e              issue_csr_op_i;
    op_ctrl_u             issue_ctrl_i;
    logic [`XLEN-1:0]     issue_result_i;
    logic [`XLEN-1:0]     issue_store_data_i;
    logic [4:0]           rs_addr_i;
    logic [`XLEN-1:0]     rs_data_o;
    logic                 retire_valid_o;
    logic [`XLEN-1:0]     retire_pc_o;
    logic                 flush_valid_o;
    logic [`XLEN-1:0]     flush_pc_o;

    logic [31:0] pat [FIELDS*MAX_REC];
    logic [31:0] regs_m [32];
    logic [31:0] mem_m [`DMEM_WORDS];
    logic [31:0] csr_m [4];           // mscratch, mtvec, mepc, mcause
    logic [31:0] exp_pc [$];
    logic        exp_flush [$];
    logic [31:0] exp_fpc [$];
    logic [31:0] lfsr = 32'hb07ecfd7;
    int          shadow;              // issue slots still dropped by a flush
    bit          in_shadow;
    int          errors;
    int          checks;
    int          cycles;
    int          limit = 1000000;
    int          num_rec;

    backend_top u_dut (
        .clock              (clock),
        .reset              (reset),
        .issue_valid_i      (issue_valid_i),
        .issue_class_i      (issue_class_i),
        .issue_pc_i         (issue_pc_i),
        .issue_rd_i         (issue_rd_i),
        .issue_csr_op_i     (issue_csr_op_i),
        .issue_ctrl_i       (issue_ctrl_i),
        .issue_result_i     (issue_result_i),
        .issue_store_data_i (issue_store_data_i),
        .rs_addr_i          (rs_addr_i),
        .rs_data_o          (rs_data_o),
        .retire_valid_o     (retire_valid_o),
        .retire_pc_o        (retire_pc_o),
        .flush_valid_o      (flush_valid_o),
        .flush_pc_o         (flush_pc_o)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout, run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ########################################################################
    // helpers
    // ########################################################################
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int csr_idx(input logic [11:0] a);
        case (a)
            12'h340: return 0;
            12'h305: return 1;
            12'h341: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic logic [31:0] load_ext(input logic [31:0] w, input logic [1:0] size,
                                             input logic uns, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = w[16*off[1] +: 16];
        if (size == 2'b00) return uns ? {24'h0, b} : {{24{b[7]}}, b};
        if (size == 2'b01) return uns ? {16'h0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one cycle, sampled at the falling edge before new inputs go out
    task automatic step();
        logic [31:0] pc;
        logic        fl;
        logic [31:0] fpc;
        @(negedge clock);
        if (retire_valid_o) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("retire of pc %h with nothing left to retire", retire_pc_o);
            end else begin
                pc  = exp_pc.pop_front();
                fl  = exp_flush.pop_front();
                fpc = exp_fpc.pop_front();
                check_value("retire pc", pc, retire_pc_o);
                check_value("flush valid", {31'h0, fl}, {31'h0, flush_valid_o});
                if (fl) check_value("flush pc", fpc, flush_pc_o);
            end
        end else if (flush_valid_o) begin
            errors++;
            $display("flush raised without a retiring item");
        end
        in_shadow = (shadow > 0);
        if (shadow > 0) shadow--;
        issue_valid_i = 1'b0;
    endtask

    task automatic model_issue(input logic [2:0] cls, input logic [31:0] pc,
                               input logic [4:0] rd, input logic [1:0] op,
                               input logic [11:0] ctrl, input logic [31:0] res,
                               input logic [31:0] sdata);
        logic [31:0] old;
        logic [31:0] nw;
        int          w;
        int          c;
        w = (res >> 2) % `DMEM_WORDS;
        c = csr_idx(ctrl);
        case (cls)
            3'd0: if (rd != 0) regs_m[rd] = res;
            3'd1: if (rd != 0) regs_m[rd] = load_ext(mem_m[w], ctrl[1:0], ctrl[2], res[1:0]);
            3'd2: begin
                if (ctrl[1:0] == 2'b00) mem_m[w][8*res[1:0] +: 8] = sdata[7:0];
                else if (ctrl[1:0] == 2'b01) mem_m[w][16*res[1] +: 16] = sdata[15:0];
                else mem_m[w] = sdata;
            end
            3'd3: begin
                old = csr_m[c];
                nw  = (op == 2'b01) ? res : (op == 2'b10) ? (old | res) : (old & ~res);
                csr_m[c] = nw;
                if (rd != 0) regs_m[rd] = old;
            end
            3'd4: begin
                csr_m[2] = pc;
                csr_m[3] = 32'd11;
            end
            default: ;
        endcase
        exp_pc.push_back(pc);
        exp_flush.push_back(cls == 3'd4 || cls == 3'd5);
        exp_fpc.push_back(cls == 3'd4 ? {csr_m[1][31:2], 2'b00} : pc + 32'd4);
    endtask

    task automatic issue(input logic [2:0] cls, input logic [31:0] pc, input logic [4:0] rd,
                         input logic [1:0] op, input logic [11:0] ctrl,
                         input logic [31:0] res, input logic [31:0] sdata);
        step();
        issue_valid_i      = 1'b1;
        issue_class_i      = instr_class_e'(cls);
        issue_pc_i         = pc;
        issue_rd_i         = rd;
        issue_csr_op_i     = csr_op_e'(op);
        issue_ctrl_i       = ctrl;
        issue_result_i     = res;
        issue_store_data_i = sdata;
        if (!in_shadow) begin
            model_issue(cls, pc, rd, op, ctrl, res, sdata);
            if (cls == 3'd4 || cls == 3'd5) shadow = 2;
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] r,
                             input logic [31:0] file_exp, input bit use_file);
        step();
        rs_addr_i = r;
        step();
        check_value(name, regs_m[r], rs_data_o);
        if (use_file) check_value({name, " pattern"}, file_exp, rs_data_o);
    endtask

    // ########################################################################
    // directed patterns and random sweep
    // ########################################################################
    task automatic play_patterns();
        int b;
        for (int i = 0; i < num_rec; i++) begin
            b = i * FIELDS;
            if (pat[b] == 0) begin
                issue(pat[b+1][2:0], pat[b+2], pat[b+3][4:0], pat[b+4][1:0],
                      pat[b+5][11:0], pat[b+6], pat[b+7]);
            end else begin
                check_reg($sformatf("pattern %0d x%0d", i, pat[b+3]), pat[b+3][4:0],
                          pat[b+8], 1'b1);
            end
        end
    endtask

    task automatic random_sweep();
        logic [1:0]  sz;
        logic [1:0]  off;
        logic [4:0]  rd;
        logic        uns;
        logic [31:0] addr;
        logic [11:0] ca;
        repeat (8) step();
        for (int i = 0; i < 16; i++) begin
            issue(3'd2, 32'h2000 + 4*i, 0, 0, 12'h002, 4*i, rand_bits(32));
        end
        for (int i = 0; i < 16; i++) begin
            rd = rand_bits(5);
            issue(3'd0, 32'h3000 + 4*i, rd, 0, 12'h000, rand_bits(32), 0);
            check_reg($sformatf("alu %0d x%0d", i, rd), rd, 0, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            addr = rand_bits(4) << 2;
            sz   = rand_bits(2) % 3;
            off  = (sz == 2'b00) ? rand_bits(2) : (sz == 2'b01) ? (rand_bits(1) << 1) : 2'b00;
            issue(3'd2, 32'h4000 + 8*i, 0, 0, {10'h0, sz}, addr | off, rand_bits(32));
            sz   = rand_bits(2) % 3;
            off  = (sz == 2'b00) ? rand_bits(2) : (sz == 2'b01) ? (rand_bits(1) << 1) : 2'b00;
            rd   = rand_bits(5);
            uns  = rand_bits(1);
            issue(3'd1, 32'h4004 + 8*i, rd, 0, {9'h0, uns, sz}, addr | off, 0);
            check_reg($sformatf("load %0d x%0d", i, rd), rd, 0, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            ca = (i % 4 == 0) ? 12'h340 : (i % 4 == 1) ? 12'h305
               : (i % 4 == 2) ? 12'h341 : 12'h342;
            rd = rand_bits(5) | 5'd1;
            issue(3'd3, 32'h5000 + 8*i, rd, 2'd1 + (i / 4), ca, rand_bits(32), 0);
            check_reg($sformatf("csr op %0d x%0d", i, rd), rd, 0, 1'b0);
            issue(3'd3, 32'h5004 + 8*i, rd, 2'd2, ca, 0, 0);  // read back
            check_reg($sformatf("csr read %0d x%0d", i, rd), rd, 0, 1'b0);
        end
        repeat (8) step();
    endtask

    initial begin
        reset              = 1'b1;
        issue_valid_i      = 1'b0;
        issue_class_i      = CL_ALU;
        issue_pc_i         = '0;
        issue_rd_i         = '0;
        issue_csr_op_i     = CSR_RW;
        issue_ctrl_i       = '0;
        issue_result_i     = '0;
        issue_store_data_i = '0;
        rs_addr_i          = '0;
        cycles             = 0;
        foreach (regs_m[i]) regs_m[i] = '0;
        foreach (csr_m[i]) csr_m[i] = '0;
        foreach (mem_m[i]) mem_m[i] = 'x;
        $readmemh("tb/backend_patterns.hex", pat);
        num_rec = 0;
        while (num_rec < MAX_REC && pat[num_rec*FIELDS] !== 32'h2) num_rec++;
        limit = 2 + 2 * num_rec + SWEEP_CYCLES + 20;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        play_patterns();
        random_sweep();
        if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d issued items never retired", exp_pc.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/backend_patterns.hex
// kind(0 issue, 1 reg check, 2 end) class pc rd csr_op ctrl result store_data expected
// ctrl is size/unsigned for loads and stores, the csr address for csr ops
0 0 00001000 05 0 000 12345678 00000000 00000000
0 0 00001004 00 0 000 0000dead 00000000 00000000
1 0 00000000 05 0 000 00000000 00000000 12345678
1 0 00000000 00 0 000 00000000 00000000 00000000
0 3 00001008 06 1 305 00002003 00000000 00000000
1 0 00000000 06 0 000 00000000 00000000 00000000
0 3 0000100c 07 2 340 0000f0f0 00000000 00000000
0 3 00001010 08 3 340 000000f0 00000000 00000000
1 0 00000000 07 0 000 00000000 00000000 00000000
1 0 00000000 08 0 000 00000000 00000000 0000f0f0
0 3 00001014 09 2 340 00000000 00000000 00000000
1 0 00000000 09 0 000 00000000 00000000 0000f000
0 2 00001018 00 0 002 00000040 a5a5a5a5 00000000
0 1 0000101c 0e 0 000 00000041 00000000 00000000
0 1 00001020 0f 0 005 00000042 00000000 00000000
1 0 00000000 0e 0 000 00000000 00000000 ffffffa5
1 0 00000000 0f 0 000 00000000 00000000 0000a5a5
0 4 00001024 00 0 000 00000000 00000000 00000000
0 2 00001028 00 0 002 00000040 ffffffff 00000000
0 0 0000102c 0b 0 000 00000001 00000000 00000000
0 1 00001030 0a 0 002 00000040 00000000 00000000
1 0 00000000 0a 0 000 00000000 00000000 a5a5a5a5
1 0 00000000 0b 0 000 00000000 00000000 00000000
0 3 00001034 0c 2 341 00000000 00000000 00000000
0 3 00001038 0d 2 342 00000000 00000000 00000000
1 0 00000000 0c 0 000 00000000 00000000 00001024
1 0 00000000 0d 0 000 00000000 00000000 0000000b
0 5 0000103c 00 0 000 00000000 00000000 00000000
2 0 00000000 00 0 000 00000000 00000000 00000000

//--- files.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/lsu_stage.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/csr_file.sv
hw/backend_top.sv
tb/backend_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = backend_tb
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
